//--- vlog.f
+incdir+src
src/bridge_pkg.sv
src/req_fifo.sv
src/axil_req_capture.sv
src/strb_to_mask.sv
src/noc_flit_builder.sv
src/noc_resp_decoder.sv
src/axil_noc_bridge.sv
verification/tb_axil_noc_bridge.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_axil_noc_bridge -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- verification/tb_axil_noc_bridge.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module tb_axil_noc_bridge;

    localparam int CLK_PERIOD      = 20;
    localparam int N_TXN           = 200;
    localparam int WATCHDOG_CYCLES = N_TXN * 40;

    logic                   clk = 1'b0;
    logic                   rst;
    bridge_pkg::axil_addr_t awaddr;
    logic                   awvalid;
    logic                   awready;
    bridge_pkg::noc_flit_t  wdata;
    bridge_pkg::axil_strb_t wstrb;
    logic                   wvalid;
    logic                   wready;
    bridge_pkg::axil_addr_t araddr;
    logic                   arvalid;
    logic                   arready;
    bridge_pkg::noc_flit_t  rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic                   noc2_valid;
    bridge_pkg::noc_flit_t  noc2_data;
    logic                   noc2_ready;
    logic                   noc3_valid;
    bridge_pkg::noc_flit_t  noc3_data;
    logic                   noc3_ready;
    bridge_pkg::noc_coord_t src_coord;
    bridge_pkg::noc_coord_t dest_coord;

    logic [15:0]            lfsr_state = 16'd26;
    logic [7:0]             mem [256];      // network memory for the 0x1000 window
    bridge_pkg::req_entry_t exp_req[$];     // acceptance order
    bridge_pkg::noc_flit_t  exp_hdr1[$];
    bridge_pkg::noc_flit_t  exp_rdata[$];
    logic                   exp_kind[$];    // 1 for an R beat
    bridge_pkg::noc_flit_t  flits[$];       // request being collected from noc2
    bridge_pkg::noc_flit_t  resp_q[$];      // flits waiting for noc3
    logic                   wr_pending = 1'b0;
    logic                   rd_pending = 1'b0;
    logic                   wr_fire = 1'b0;
    logic                   rd_fire = 1'b0;
    logic                   noc3_fire = 1'b0;
    bridge_pkg::data_size_t wr_size;
    logic [2:0]             wr_off;
    int                     issued = 0;
    int                     n_writes = 0;
    int                     n_reads = 0;
    int                     n_b = 0;
    int                     n_r = 0;
    int                     checks = 0;
    int                     errors = 0;

    axil_noc_bridge i_axil_noc_bridge (
        .clk        (clk),
        .rst        (rst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .noc2_valid (noc2_valid),
        .noc2_data  (noc2_data),
        .noc2_ready (noc2_ready),
        .noc3_valid (noc3_valid),
        .noc3_data  (noc3_data),
        .noc3_ready (noc3_ready),
        .src_coord  (src_coord),
        .dest_coord (dest_coord)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    task automatic check_flit(input string name, input bridge_pkg::noc_flit_t exp,
                              input bridge_pkg::noc_flit_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED at %0d ns: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input bridge_pkg::axil_addr_t exp,
                              input bridge_pkg::axil_addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED at %0d ns: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_size(input string name, input bridge_pkg::data_size_t exp,
                              input bridge_pkg::data_size_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED at %0d ns: %s expected %0d, actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED at %0d ns: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED at %0d ns: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_idle_outputs();
        check_bit("awready", 1'b0, awready);
        check_bit("wready", 1'b0, wready);
        check_bit("arready", 1'b0, arready);
        check_bit("noc2_valid", 1'b0, noc2_valid);
        check_bit("bvalid", 1'b0, bvalid);
        check_bit("rvalid", 1'b0, rvalid);
        check_bit("noc3_ready", 1'b1, noc3_ready);
    endtask

    task automatic start_write();
        logic [63:0] r;
        int          nbytes;
        take_bits(8, r);
        awaddr = {24'h000010, r[7:0]};
        take_bits(2, r);
        nbytes  = 1 << r[1:0];                  // 1, 2, 4 or 8 bytes
        wr_size = 3'(r[1:0]) + 3'd1;
        take_bits(3, r);
        wr_off = r[2:0] & 3'(8 - nbytes);       // natural alignment
        wstrb  = (8'hff >> (8 - nbytes)) << wr_off;
        take_bits(64, r);
        wdata      = r;
        wr_pending = 1'b1;
        issued++;
    endtask

    task automatic start_read();
        logic [63:0] r;
        take_bits(5, r);
        araddr     = {24'h000010, r[4:0], 3'b000};
        rd_pending = 1'b1;
        issued++;
    endtask

    task automatic drive();
        logic [63:0] r;
        if (wr_fire) wr_pending = 1'b0;
        if (rd_fire) rd_pending = 1'b0;
        if (noc3_fire && resp_q.size() != 0) void'(resp_q.pop_front());
        if (!wr_pending && issued < N_TXN) begin
            take_bits(1, r);
            if (r[0]) start_write();
        end
        if (!rd_pending && issued < N_TXN) begin
            take_bits(1, r);
            if (r[0]) start_read();
        end
        awvalid = wr_pending;
        wvalid  = wr_pending;
        arvalid = rd_pending;
        take_bits(2, r);
        noc2_ready = (r[1:0] != 2'b00);   // about one stall in four
        take_bits(2, r);
        rready = (r[1:0] != 2'b00);
        take_bits(2, r);
        bready = (r[1:0] != 2'b00);
        noc3_valid = (resp_q.size() != 0);
        noc3_data  = '0;
        if (noc3_valid) noc3_data = resp_q[0];
    endtask

    // decode one complete request from noc2, update memory and queue the ack
    task automatic check_request();
        bridge_pkg::req_entry_t e;
        bridge_pkg::noc_flit_t  hdr1;
        bridge_pkg::noc_flit_t  d;
        bridge_pkg::axil_addr_t a;
        logic [7:0]             idx;
        int                     nb;
        if (exp_req.size() == 0) begin
            report_error("noc2 request without an accepted AXI request");
            flits.delete();
            return;
        end
        e    = exp_req.pop_front();
        hdr1 = exp_hdr1.pop_front();
        check_flit("noc2 header 0", {dest_coord.x, dest_coord.y, e.is_store ? 8'd3 : 8'd2,
            e.is_store ? `BRIDGE_MSG_STORE_REQ : `BRIDGE_MSG_LOAD_REQ, 32'h0}, flits[0]);
        check_addr("noc2 header 1 address", hdr1[63:32], flits[1][63:32]);
        check_size("noc2 header 1 size", hdr1[2:0], flits[1][2:0]);
        check_flit("noc2 header 1", hdr1, flits[1]);
        check_flit("noc2 header 2", {src_coord.x, src_coord.y, 48'h0}, flits[2]);
        a = flits[1][63:32];
        if (e.is_store && flits.size() == 4) begin
            check_flit("noc2 data", e.wdata, flits[3]);
            d = flits[3];
            case (flits[1][2:0])
                3'd1:    nb = 1;
                3'd2:    nb = 2;
                3'd3:    nb = 4;
                3'd4:    nb = 8;
                default: nb = 0;
            endcase
            for (int b = 0; b < nb; b++) begin
                idx      = a[7:0] + 8'(b);
                mem[idx] = d[8 * (int'(a[2:0]) + b) +: 8];
            end
            resp_q.push_back({16'h0, 8'd0, `BRIDGE_MSG_STORE_ACK, 32'h0});
            exp_kind.push_back(1'b0);
        end else if (!e.is_store && flits.size() == 3) begin
            for (int b = 0; b < 8; b++) d[8 * b +: 8] = mem[{a[7:3], 3'(b)}];
            resp_q.push_back({16'h0, 8'd1, `BRIDGE_MSG_LOAD_ACK, 32'h0});
            resp_q.push_back(d);
            exp_rdata.push_back(d);
            exp_kind.push_back(1'b1);
        end else begin
            report_error("noc2 request has the wrong number of flits for its kind");
        end
        flits.delete();
    endtask

    task automatic observe();
        bridge_pkg::req_entry_t e;
        logic                   room;
        // queued model requests mirror the request FIFO occupancy
        room      = (exp_req.size() < `BRIDGE_FIFO_DEPTH);
        wr_fire   = awvalid && awready;
        rd_fire   = arvalid && arready;
        noc3_fire = noc3_valid && noc3_ready;
        if (awvalid && arready) report_error("arready high while a write address is waiting");
        check_bit("awready", awvalid && wvalid && room, awready);
        check_bit("wready", awvalid && wvalid && room, wready);
        if (!room) check_bit("arready", 1'b0, arready);
        if (wr_fire) begin
            e.is_store = 1'b1;
            e.addr     = awaddr;
            e.wdata    = wdata;
            e.strb     = wstrb;
            exp_req.push_back(e);
            exp_hdr1.push_back({awaddr[31:3], wr_off, 29'h0, wr_size});
            n_writes++;
        end
        if (rd_fire) begin
            e          = '0;
            e.addr     = araddr;
            exp_req.push_back(e);
            exp_hdr1.push_back({araddr, 29'h0, 3'd4});  // loads are full words
            n_reads++;
        end
        if (noc2_valid && noc2_ready) begin
            flits.push_back(noc2_data);
            if (flits.size() == ((flits[0][39:32] == `BRIDGE_MSG_STORE_REQ) ? 4 : 3))
                check_request();
        end
        if (bvalid && bready) begin
            n_b++;
            if (exp_kind.size() == 0 || exp_kind[0]) report_error("B beat not expected here");
            else void'(exp_kind.pop_front());
            check_resp("bresp", 2'b00, bresp);
        end
        if (rvalid && rready) begin
            n_r++;
            if (exp_kind.size() == 0 || !exp_kind[0]) begin
                report_error("R beat not expected here");
            end else begin
                void'(exp_kind.pop_front());
                check_flit("rdata", exp_rdata.pop_front(), rdata);
            end
            check_resp("rresp", 2'b00, rresp);
        end
    endtask

    initial begin
        #(CLK_PERIOD * (WATCHDOG_CYCLES + 8));
        $display("timeout: the transactions did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        bready       = 1'b0;
        noc2_ready   = 1'b0;
        noc3_valid   = 1'b0;
        noc3_data    = '0;
        src_coord.x  = 8'h02;
        src_coord.y  = 8'h01;
        dest_coord.x = 8'h05;
        dest_coord.y = 8'h03;
        for (int i = 0; i < 256; i++) mem[i] = 8'(i) ^ 8'h3c;
        repeat (7) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_idle_outputs();   // first cycle out of reset
        while (n_b + n_r < N_TXN) begin
            @(posedge clk);
            #1;
            drive();
            @(negedge clk);
            observe();
        end
        if (exp_req.size() != 0 || resp_q.size() != 0 || exp_kind.size() != 0)
            report_error("requests or responses are left over at the end");
        if (n_b != n_writes) report_error("number of B beats differs from the number of writes");
        if (n_r != n_reads) report_error("number of R beats differs from the number of reads");
        $display("writes %0d, reads %0d, checks %0d, errors %0d", n_writes, n_reads, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- src/axil_noc_bridge.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module axil_noc_bridge (
    input  logic                   clk,
    input  logic                   rst,
    input  bridge_pkg::axil_addr_t awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  bridge_pkg::noc_flit_t  wdata,
    input  bridge_pkg::axil_strb_t wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    input  bridge_pkg::axil_addr_t araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output bridge_pkg::noc_flit_t  rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    output logic                   noc2_valid,
    output bridge_pkg::noc_flit_t  noc2_data,
    input  logic                   noc2_ready,
    input  logic                   noc3_valid,
    input  bridge_pkg::noc_flit_t  noc3_data,
    output logic                   noc3_ready,
    input  bridge_pkg::noc_coord_t src_coord,
    input  bridge_pkg::noc_coord_t dest_coord
);

    logic                   fifo_push;
    logic                   fifo_pop;
    logic                   fifo_full;
    logic                   fifo_empty;
    bridge_pkg::req_entry_t push_entry;
    bridge_pkg::req_entry_t head_entry;

    // request path, AXI to noc2
    axil_req_capture i_axil_req_capture (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .full    (fifo_full),
        .push    (fifo_push),
        .entry   (push_entry)
    );

    req_fifo #(.DEPTH(`BRIDGE_FIFO_DEPTH)) i_req_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (fifo_push),
        .entry_in (push_entry),
        .pop      (fifo_pop),
        .head     (head_entry),
        .full     (fifo_full),
        .empty    (fifo_empty)
    );

    noc_flit_builder i_noc_flit_builder (
        .clk        (clk),
        .rst        (rst),
        .head       (head_entry),
        .empty      (fifo_empty),
        .pop        (fifo_pop),
        .src_coord  (src_coord),
        .dest_coord (dest_coord),
        .noc2_valid (noc2_valid),
        .noc2_data  (noc2_data),
        .noc2_ready (noc2_ready)
    );

    // response path, noc3 to B and R
    noc_resp_decoder i_noc_resp_decoder (
        .clk        (clk),
        .rst        (rst),
        .noc3_valid (noc3_valid),
        .noc3_data  (noc3_data),
        .noc3_ready (noc3_ready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready)
    );

endmodule

//--- src/noc_resp_decoder.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module noc_resp_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  noc3_valid,
    input  bridge_pkg::noc_flit_t noc3_data,
    output logic                  noc3_ready,
    output bridge_pkg::noc_flit_t rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready
);

    typedef enum logic [1:0] {
        resp_hdr,
        resp_data,
        resp_b,
        resp_r
    } resp_state_e;

    resp_state_e           state;
    logic                  noc3_fire;
    bridge_pkg::msg_type_t ack_type;
    logic [7:0]            ack_len;

    assign noc3_ready = (state == resp_hdr) || (state == resp_data);
    assign noc3_fire  = noc3_valid && noc3_ready;
    assign ack_type   = noc3_data[`BRIDGE_F_TYPE];
    assign ack_len    = noc3_data[`BRIDGE_F_LEN];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= resp_hdr;
        end else begin
            case (state)
                resp_hdr: begin
                    if (noc3_fire && ack_type == `BRIDGE_MSG_LOAD_ACK) state <= resp_data;
                    else if (noc3_fire && ack_type == `BRIDGE_MSG_STORE_ACK) state <= resp_b;
                end
                resp_data: if (noc3_fire) state <= resp_r;
                resp_b:    if (bready) state <= resp_hdr;
                default:   if (rready) state <= resp_hdr;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == resp_data && noc3_fire) rdata <= noc3_data; // load payload
    end

    assign bvalid = (state == resp_b);
    assign rvalid = (state == resp_r);
    assign bresp  = 2'b00;  // OKAY
    assign rresp  = 2'b00;

    // header must be a known ack with the length that goes with it
    a_known_ack: assert property (@(posedge clk) disable iff (rst)
        noc3_fire && state == resp_hdr |->
            (ack_type == `BRIDGE_MSG_STORE_ACK && ack_len == 8'd0) ||
            (ack_type == `BRIDGE_MSG_LOAD_ACK && ack_len == 8'd1));

endmodule

//--- src/noc_flit_builder.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module noc_flit_builder (
    input  logic                   clk,
    input  logic                   rst,
    input  bridge_pkg::req_entry_t head,
    input  logic                   empty,
    output logic                   pop,
    input  bridge_pkg::noc_coord_t src_coord,
    input  bridge_pkg::noc_coord_t dest_coord,
    output logic                   noc2_valid,
    output bridge_pkg::noc_flit_t  noc2_data,
    input  logic                   noc2_ready
);

    localparam logic [1:0] HDR_LAST = 2'(`BRIDGE_HDR_FLITS - 1);

    bridge_pkg::flit_state_e state;
    logic [1:0]              flit_cnt;   // header flit index
    logic                    flit_fire;
    logic                    last_hdr;
    bridge_pkg::axil_strb_t  store_strb;
    bridge_pkg::data_size_t  st_size;
    logic [2:0]              st_offset;
    bridge_pkg::msg_type_t   msg_type;
    logic [7:0]              msg_len;

    // only a queued store carries a strobe
    assign store_strb = (!empty && head.is_store) ? head.strb : '0;

    strb_to_mask i_strb_to_mask (
        .strb   (store_strb),
        .size   (st_size),
        .offset (st_offset)
    );

    assign noc2_valid = (state != bridge_pkg::idle);
    assign flit_fire  = noc2_valid && noc2_ready;
    assign last_hdr   = (state == bridge_pkg::header) && (flit_cnt == HDR_LAST);
    assign pop = flit_fire && ((state == bridge_pkg::data) || (last_hdr && !head.is_store));

    assign msg_type = head.is_store ? `BRIDGE_MSG_STORE_REQ : `BRIDGE_MSG_LOAD_REQ;
    assign msg_len  = head.is_store ? 8'd3 : 8'd2;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= bridge_pkg::idle;
            flit_cnt <= '0;
        end else begin
            case (state)
                bridge_pkg::idle: begin
                    flit_cnt <= '0;
                    if (!empty) state <= bridge_pkg::header;
                end
                bridge_pkg::header: begin
                    if (flit_fire && last_hdr) begin
                        flit_cnt <= '0;
                        if (head.is_store) state <= bridge_pkg::data;
                        else state <= bridge_pkg::idle;
                    end else if (flit_fire) begin
                        flit_cnt <= flit_cnt + 2'd1;
                    end
                end
                default: begin
                    if (flit_fire) state <= bridge_pkg::idle; // data flit taken
                end
            endcase
        end
    end

    always_comb begin
        noc2_data = '0;
        if (state == bridge_pkg::header) begin
            case (flit_cnt)
                2'd0: begin
                    noc2_data[`BRIDGE_F_DST_X] = dest_coord.x;
                    noc2_data[`BRIDGE_F_DST_Y] = dest_coord.y;
                    noc2_data[`BRIDGE_F_LEN]   = msg_len;
                    noc2_data[`BRIDGE_F_TYPE]  = msg_type;
                end
                2'd1: begin
                    if (head.is_store) begin
                        noc2_data[`BRIDGE_F_ADDR] = {head.addr[31:3], st_offset};
                        noc2_data[`BRIDGE_F_SIZE] = st_size;
                    end else begin
                        noc2_data[`BRIDGE_F_ADDR] = head.addr;
                        noc2_data[`BRIDGE_F_SIZE] = 3'd4; // loads are full words
                    end
                end
                default: begin
                    noc2_data[`BRIDGE_F_SRC_X] = src_coord.x;
                    noc2_data[`BRIDGE_F_SRC_Y] = src_coord.y;
                end
            endcase
        end else if (state == bridge_pkg::data) begin
            noc2_data = head.wdata;
        end
    end

    // network rule, flit held until taken
    a_flit_stable: assert property (@(posedge clk) disable iff (rst)
        noc2_valid && !noc2_ready |=> noc2_valid && $stable(noc2_data));

endmodule

//--- src/strb_to_mask.sv
`timescale 1ns/1ps

module strb_to_mask (
    input  bridge_pkg::axil_strb_t strb,
    output bridge_pkg::data_size_t size,
    output logic [2:0]             offset
);

    logic [3:0] n_bytes;

    always_comb begin
        n_bytes = '0;
        offset  = '0;
        for (int i = 7; i >= 0; i--) begin
            n_bytes = n_bytes + 4'(strb[i]);
            if (strb[i]) offset = 3'(i);   // lowest set byte wins
        end
        case (n_bytes)
            4'd1:    size = 3'd1;
            4'd2:    size = 3'd2;
            4'd4:    size = 3'd3;
            default: size = 3'd4; // full word, also for an empty strobe
        endcase
    end

    // contiguous and naturally aligned, or zero for a load
    always_comb begin
        a_legal_strb: assert (strb inside {8'h00, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
            8'h20, 8'h40, 8'h80, 8'h03, 8'h0c, 8'h30, 8'hc0, 8'h0f, 8'hf0, 8'hff});
    end

endmodule

//--- src/axil_req_capture.sv
`timescale 1ns/1ps

module axil_req_capture (
    input  logic                   clk,
    input  logic                   rst,
    input  bridge_pkg::axil_addr_t awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  bridge_pkg::noc_flit_t  wdata,
    input  bridge_pkg::axil_strb_t wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    input  bridge_pkg::axil_addr_t araddr,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic                   full,
    output logic                   push,
    output bridge_pkg::req_entry_t entry
);

    logic wr_take;
    logic rd_take;

    // write needs address and data together
    assign wr_take = awvalid && wvalid && !full;
    // a pending write address blocks reads
    assign rd_take = arvalid && !awvalid && !full;

    assign awready = wr_take;
    assign wready  = wr_take;
    assign arready = rd_take;
    assign push    = wr_take || rd_take;

    always_comb begin
        entry.is_store = wr_take;
        entry.addr     = wr_take ? awaddr : araddr;
        entry.wdata    = wdata;
        entry.strb     = wr_take ? wstrb : '0; // loads carry no strobe
    end

endmodule

//--- src/req_fifo.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module req_fifo #(
    parameter int DEPTH = `BRIDGE_FIFO_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  bridge_pkg::req_entry_t entry_in,
    input  logic                   pop,
    output bridge_pkg::req_entry_t head,
    output logic                   full,
    output logic                   empty
);

    localparam int PTR_W = $clog2(DEPTH);

    bridge_pkg::req_entry_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;   // one extra bit to hold DEPTH

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= entry_in;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // wraps at power of two
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign full  = (count == (PTR_W+1)'(DEPTH));
    assign empty = (count == '0);

    // builder must only retire an entry that is really queued
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- src/bridge_pkg.sv
`include "bridge_settings.svh"

package bridge_pkg;

    typedef logic [`BRIDGE_ADDR_W-1:0]   axil_addr_t;
    typedef logic [`BRIDGE_DATA_W-1:0]   noc_flit_t;
    typedef logic [`BRIDGE_DATA_W/8-1:0] axil_strb_t;
    typedef logic [7:0]                  msg_type_t;

    // 1 = 1 byte, 2 = 2 bytes, 3 = 4 bytes, 4 = 8 bytes
    typedef logic [2:0]                  data_size_t;

    // mesh tile position
    typedef struct packed {
        logic [7:0] x;
        logic [7:0] y;
    } noc_coord_t;

    // one queued AXI request, 105 bits
    typedef struct packed {
        logic       is_store;
        axil_addr_t addr;
        noc_flit_t  wdata;
        axil_strb_t strb;     // zero for loads
    } req_entry_t;

    typedef enum logic [1:0] {
        idle,
        header,
        data
    } flit_state_e;

endpackage

//--- src/bridge_settings.svh
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

`define BRIDGE_ADDR_W        32
`define BRIDGE_DATA_W        64   // also the flit width
`define BRIDGE_FIFO_DEPTH    16
`define BRIDGE_MSG_LOAD_REQ  8'd14
`define BRIDGE_MSG_STORE_REQ 8'd15
`define BRIDGE_MSG_LOAD_ACK  8'd24
`define BRIDGE_MSG_STORE_ACK 8'd25
`define BRIDGE_HDR_FLITS     3

// flit field positions
`define BRIDGE_F_DST_X 63:56 // header 0
`define BRIDGE_F_DST_Y 55:48
`define BRIDGE_F_LEN   47:40
`define BRIDGE_F_TYPE  39:32
`define BRIDGE_F_ADDR  63:32 // header 1
`define BRIDGE_F_SIZE  2:0
`define BRIDGE_F_SRC_X 63:56 // header 2
`define BRIDGE_F_SRC_Y 55:48

`endif
